// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_arcade_input
FILELIST  ?= arcade_input.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation run passed"; \
	else \
		echo "simulation run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: arcade_cfg_pkg.sv
package arcade_cfg_pkg;

	typedef logic [3:0] apb_addr_t;
	typedef logic [7:0] cfg_word_t;
	typedef logic [7:0] dip_t;

	localparam apb_addr_t cfg_ctrl_addr   = 4'h0; // Read/write
	localparam apb_addr_t cfg_status_addr = 4'h4; // Read only

	// CTRL fields
	localparam int cfg_rotate     = 0;
	localparam int cfg_soft_reset = 1;
	localparam int cfg_lives_lo   = 2;
	localparam int cfg_lives_hi   = 3;
	localparam int cfg_bonus_lo   = 4;
	localparam int cfg_bonus_hi   = 5;
	localparam int cfg_upright    = 6;

	localparam cfg_word_t cfg_ctrl_default = 8'h00;
	localparam cfg_word_t cfg_ctrl_mask    = 8'h7F; // Bit 7 unused

	// Board DIP byte: cabinet, three unused, bonus, lives
	function automatic dip_t dip_from_ctrl(input cfg_word_t ctrl);
		return {~ctrl[cfg_upright], 3'b000,
			ctrl[cfg_bonus_hi:cfg_bonus_lo],
			ctrl[cfg_lives_hi:cfg_lives_lo]};
	endfunction

endpackage

// File: arcade_input.f
arcade_input_pkg.sv
arcade_cfg_pkg.sv
key_latch.sv
joy_merge.sv
control_mapper.sv
cfg_regs_apb.sv
arcade_input_top.sv
arcade_input_asserts.sv
tb_arcade_input.sv

// File: arcade_input_asserts.sv
`timescale 1ns/1ps

module arcade_input_asserts (
	input logic                          clock_24,
	input logic                          rst,
	input arcade_input_pkg::key_state_t  key_state,
	input arcade_input_pkg::joy_t        joy_merged,
	input arcade_cfg_pkg::cfg_word_t     cfg_ctrl,
	input logic                          up_n,
	input logic                          down_n,
	input logic                          left_n,
	input logic                          right_n,
	input logic                          fire_n,
	input logic                          coin_n,
	input logic                          start1_n,
	input logic                          start2_n,
	input arcade_cfg_pkg::dip_t          dip_sw,
	input logic                          game_reset_n,
	input arcade_input_pkg::key_state_t  ctrl_state
);

	int unsigned fail_count = 0;
	logic [4:0] merged;
	logic [7:0] expect_ctrl;
	logic [7:0] outs_n;

	assign merged = key_state[4:0] | joy_merged; // Keys and sticks share the low bits
	assign outs_n = {start2_n, start1_n, coin_n, fire_n, up_n, down_n, left_n, right_n};

	// Quarter turn takes up from left, down from right, left from down, right from up
	assign expect_ctrl = cfg_ctrl[0]
		? {key_state[7:5], merged[4], merged[1], merged[0], merged[2], merged[3]}
		: {key_state[7:5], merged};

	a_controls: assert property (@(posedge clock_24) disable iff (rst)
		outs_n == ~$past(expect_ctrl) && ctrl_state == $past(expect_ctrl))
		else begin
			$error("controls do not follow the mapped keyboard and joystick state");
			fail_count++;
		end

	a_dip: assert property (@(posedge clock_24) disable iff (rst)
		dip_sw == $past({~cfg_ctrl[6], 3'b000, cfg_ctrl[5:4], cfg_ctrl[3:2]}))
		else begin
			$error("DIP byte does not match the cabinet, bonus and lives fields");
			fail_count++;
		end

	a_game_reset: assert property (@(posedge clock_24) disable iff (rst)
		game_reset_n == !$past(rst | cfg_ctrl[1] | (key_state[5] & key_state[6])))
		else begin
			$error("game reset does not follow rst, soft reset and the coin/start chord");
			fail_count++;
		end

	a_soft_pulse: assert property (@(posedge clock_24) disable iff (rst)
		cfg_ctrl[1] |=> !cfg_ctrl[1])
		else begin
			$error("soft reset bit stayed set for more than one cycle");
			fail_count++;
		end

	a_reset_state: assert property (@(posedge clock_24)
		rst |=> outs_n == 8'hFF && dip_sw == 8'h80 && !game_reset_n && ctrl_state == 8'h00)
		else begin
			$error("outputs are not at their idle values during reset");
			fail_count++;
		end

endmodule

bind control_mapper arcade_input_asserts mapper_chk (.*);

// File: arcade_input_pkg.sv
package arcade_input_pkg;

	typedef logic [7:0] scan_code_t;
	typedef logic [4:0] joy_t;
	typedef logic [7:0] key_state_t;

	// PS/2 set 2 codes of the player keys
	localparam scan_code_t sc_up     = 8'h75;
	localparam scan_code_t sc_down   = 8'h72;
	localparam scan_code_t sc_left   = 8'h6B;
	localparam scan_code_t sc_right  = 8'h74;
	localparam scan_code_t sc_coin   = 8'h76; // Escape
	localparam scan_code_t sc_start1 = 8'h05; // F1
	localparam scan_code_t sc_start2 = 8'h06; // F2
	localparam scan_code_t sc_fire   = 8'h29; // Space

	// Joystick bits, as delivered by the host
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;

	// Button bits, low five shared with the joystick layout
	localparam int key_right  = 0;
	localparam int key_left   = 1;
	localparam int key_down   = 2;
	localparam int key_up     = 3;
	localparam int key_fire   = 4;
	localparam int key_coin   = 5;
	localparam int key_start1 = 6;
	localparam int key_start2 = 7;

endpackage

// File: arcade_input_top.sv
`timescale 1ns/1ps

module arcade_input_top #(
	parameter int sync_stages = 2
) (
	input  logic                          clock_24,
	input  logic                          rst,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  arcade_cfg_pkg::apb_addr_t     paddr,
	input  arcade_cfg_pkg::cfg_word_t     pwdata,
	output arcade_cfg_pkg::cfg_word_t     prdata,
	output logic                          pready,
	output logic                          pslverr,
	input  logic                          key_strobe,
	input  logic                          key_pressed,
	input  arcade_input_pkg::scan_code_t  key_code,
	input  arcade_input_pkg::joy_t        joystick_0,
	input  arcade_input_pkg::joy_t        joystick_1,
	output logic                          up_n,
	output logic                          down_n,
	output logic                          left_n,
	output logic                          right_n,
	output logic                          fire_n,
	output logic                          coin_n,
	output logic                          start1_n,
	output logic                          start2_n,
	output arcade_cfg_pkg::dip_t          dip_sw,
	output logic                          game_reset_n
);

	arcade_input_pkg::key_state_t key_state;
	arcade_input_pkg::joy_t       joy_merged;
	arcade_cfg_pkg::cfg_word_t    cfg_ctrl;
	arcade_input_pkg::key_state_t ctrl_state;

	key_latch u_key_latch (
		.clock_24    (clock_24),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.key_state   (key_state)
	);

	joy_merge #(
		.sync_stages (sync_stages)
	) u_joy_merge (
		.clock_24   (clock_24),
		.rst        (rst),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joy_merged (joy_merged)
	);

	control_mapper u_control_mapper (
		.clock_24     (clock_24),
		.rst          (rst),
		.key_state    (key_state),
		.joy_merged   (joy_merged),
		.cfg_ctrl     (cfg_ctrl),
		.up_n         (up_n),
		.down_n       (down_n),
		.left_n       (left_n),
		.right_n      (right_n),
		.fire_n       (fire_n),
		.coin_n       (coin_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.dip_sw       (dip_sw),
		.game_reset_n (game_reset_n),
		.ctrl_state   (ctrl_state)
	);

	cfg_regs_apb u_cfg_regs_apb (
		.clock_24   (clock_24),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.ctrl_state (ctrl_state),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.cfg_ctrl   (cfg_ctrl)
	);

endmodule

// File: cfg_regs_apb.sv
`timescale 1ns/1ps

module cfg_regs_apb (
	input  logic                          clock_24,
	input  logic                          rst,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  arcade_cfg_pkg::apb_addr_t     paddr,
	input  arcade_cfg_pkg::cfg_word_t     pwdata,
	input  arcade_input_pkg::key_state_t  ctrl_state,
	output arcade_cfg_pkg::cfg_word_t     prdata,
	output logic                          pready,
	output logic                          pslverr,
	output arcade_cfg_pkg::cfg_word_t     cfg_ctrl
);

	logic access;
	logic addr_ctrl;
	logic addr_status;
	logic bad_addr;
	logic wr_ctrl;
	logic rd_access;

	assign access      = psel & penable;
	assign addr_ctrl   = (paddr == arcade_cfg_pkg::cfg_ctrl_addr);
	assign addr_status = (paddr == arcade_cfg_pkg::cfg_status_addr);

	// STATUS is read only, anything else unmapped
	assign bad_addr = pwrite ? ~addr_ctrl : ~(addr_ctrl | addr_status);

	assign wr_ctrl   = access & pwrite & addr_ctrl;
	assign rd_access = access & ~pwrite;

	assign pready  = 1'b1; // Zero wait states
	assign pslverr = access & bad_addr;

	always_comb begin
		prdata = '0;
		if (rd_access) begin
			if (addr_ctrl) begin
				prdata = cfg_ctrl;
			end else if (addr_status) begin
				prdata = ctrl_state; // Live controls after rotation
			end
		end
	end

	// Soft reset bit drops on the next edge, giving a one-cycle pulse
	always_ff @(posedge clock_24) begin
		if (rst) begin
			cfg_ctrl <= arcade_cfg_pkg::cfg_ctrl_default;
		end else if (wr_ctrl) begin
			cfg_ctrl <= pwdata & arcade_cfg_pkg::cfg_ctrl_mask;
		end else begin
			cfg_ctrl[arcade_cfg_pkg::cfg_soft_reset] <= 1'b0;
		end
	end

endmodule

// File: control_mapper.sv
`timescale 1ns/1ps

module control_mapper (
	input  logic                          clock_24,
	input  logic                          rst,
	input  arcade_input_pkg::key_state_t  key_state,
	input  arcade_input_pkg::joy_t        joy_merged,
	input  arcade_cfg_pkg::cfg_word_t     cfg_ctrl,
	output logic                          up_n,
	output logic                          down_n,
	output logic                          left_n,
	output logic                          right_n,
	output logic                          fire_n,
	output logic                          coin_n,
	output logic                          start1_n,
	output logic                          start2_n,
	output arcade_cfg_pkg::dip_t          dip_sw,
	output logic                          game_reset_n,
	output arcade_input_pkg::key_state_t  ctrl_state
);

	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;
	logic rotate;
	logic reset_chord;
	arcade_input_pkg::key_state_t ctrl_next;
	arcade_input_pkg::key_state_t ctrl_n;

	assign m_up    = key_state[arcade_input_pkg::key_up] | joy_merged[arcade_input_pkg::joy_up];
	assign m_down  = key_state[arcade_input_pkg::key_down] | joy_merged[arcade_input_pkg::joy_down];
	assign m_left  = key_state[arcade_input_pkg::key_left] | joy_merged[arcade_input_pkg::joy_left];
	assign m_right = key_state[arcade_input_pkg::key_right]
		| joy_merged[arcade_input_pkg::joy_right];
	assign m_fire  = key_state[arcade_input_pkg::key_fire] | joy_merged[arcade_input_pkg::joy_fire];

	assign rotate = cfg_ctrl[arcade_cfg_pkg::cfg_rotate];

	// Rotated monitor turns the stick a quarter turn
	always_comb begin
		ctrl_next = '0;
		ctrl_next[arcade_input_pkg::key_up]     = rotate ? m_left : m_up;
		ctrl_next[arcade_input_pkg::key_down]   = rotate ? m_right : m_down;
		ctrl_next[arcade_input_pkg::key_left]   = rotate ? m_down : m_left;
		ctrl_next[arcade_input_pkg::key_right]  = rotate ? m_up : m_right;
		ctrl_next[arcade_input_pkg::key_fire]   = m_fire;
		ctrl_next[arcade_input_pkg::key_coin]   = key_state[arcade_input_pkg::key_coin];
		ctrl_next[arcade_input_pkg::key_start1] = key_state[arcade_input_pkg::key_start1];
		ctrl_next[arcade_input_pkg::key_start2] = key_state[arcade_input_pkg::key_start2];
	end

	always_ff @(posedge clock_24) begin
		if (rst) begin
			ctrl_state <= '0;
			ctrl_n     <= '1; // Board inputs idle high
			dip_sw     <= arcade_cfg_pkg::dip_from_ctrl(arcade_cfg_pkg::cfg_ctrl_default);
		end else begin
			ctrl_state <= ctrl_next;
			ctrl_n     <= ~ctrl_next;
			dip_sw     <= arcade_cfg_pkg::dip_from_ctrl(cfg_ctrl);
		end
	end

	assign up_n     = ctrl_n[arcade_input_pkg::key_up];
	assign down_n   = ctrl_n[arcade_input_pkg::key_down];
	assign left_n   = ctrl_n[arcade_input_pkg::key_left];
	assign right_n  = ctrl_n[arcade_input_pkg::key_right];
	assign fire_n   = ctrl_n[arcade_input_pkg::key_fire];
	assign coin_n   = ctrl_n[arcade_input_pkg::key_coin];
	assign start1_n = ctrl_n[arcade_input_pkg::key_start1];
	assign start2_n = ctrl_n[arcade_input_pkg::key_start2];

	// Coin plus 1P start held is the service reset
	assign reset_chord = key_state[arcade_input_pkg::key_coin]
		& key_state[arcade_input_pkg::key_start1];

	always_ff @(posedge clock_24) begin
		game_reset_n <= ~(rst | cfg_ctrl[arcade_cfg_pkg::cfg_soft_reset] | reset_chord);
	end

endmodule

// File: joy_merge.sv
`timescale 1ns/1ps

module joy_merge #(
	parameter int sync_stages = 2
) (
	input  logic                    clock_24,
	input  logic                    rst,
	input  arcade_input_pkg::joy_t  joystick_0,
	input  arcade_input_pkg::joy_t  joystick_1,
	output arcade_input_pkg::joy_t  joy_merged
);

	arcade_input_pkg::joy_t sync_0 [sync_stages];
	arcade_input_pkg::joy_t sync_1 [sync_stages];
	arcade_input_pkg::joy_t joy_0_s;
	arcade_input_pkg::joy_t joy_1_s;

	// Metastability chains, one per stick
	always_ff @(posedge clock_24) begin
		if (rst) begin
			for (int i = 0; i < sync_stages; i++) begin
				sync_0[i] <= '0;
				sync_1[i] <= '0;
			end
		end else begin
			sync_0[0] <= joystick_0;
			sync_1[0] <= joystick_1;
			for (int i = 1; i < sync_stages; i++) begin
				sync_0[i] <= sync_0[i-1];
				sync_1[i] <= sync_1[i-1];
			end
		end
	end

	assign joy_0_s = sync_0[sync_stages-1];
	assign joy_1_s = sync_1[sync_stages-1];

	// Either player drives the single control set
	always_ff @(posedge clock_24) begin
		if (rst) begin
			joy_merged <= '0;
		end else begin
			joy_merged <= joy_0_s | joy_1_s;
		end
	end

endmodule

// File: key_latch.sv
`timescale 1ns/1ps

module key_latch (
	input  logic                          clock_24,
	input  logic                          rst,
	input  logic                          key_strobe,
	input  logic                          key_pressed,
	input  arcade_input_pkg::scan_code_t  key_code,
	output arcade_input_pkg::key_state_t  key_state
);

	arcade_input_pkg::key_state_t key_hit;

	// One-hot button select for the incoming code
	always_comb begin
		key_hit = '0;
		case (key_code)
			arcade_input_pkg::sc_up:
				key_hit[arcade_input_pkg::key_up] = 1'b1;
			arcade_input_pkg::sc_down:
				key_hit[arcade_input_pkg::key_down] = 1'b1;
			arcade_input_pkg::sc_left:
				key_hit[arcade_input_pkg::key_left] = 1'b1;
			arcade_input_pkg::sc_right:
				key_hit[arcade_input_pkg::key_right] = 1'b1;
			arcade_input_pkg::sc_fire:
				key_hit[arcade_input_pkg::key_fire] = 1'b1;
			arcade_input_pkg::sc_coin:
				key_hit[arcade_input_pkg::key_coin] = 1'b1;
			arcade_input_pkg::sc_start1:
				key_hit[arcade_input_pkg::key_start1] = 1'b1;
			arcade_input_pkg::sc_start2:
				key_hit[arcade_input_pkg::key_start2] = 1'b1;
			default: key_hit = '0; // Unknown keys ignored
		endcase
	end

	// Make sets the bit, break clears it
	always_ff @(posedge clock_24) begin
		if (rst) begin
			key_state <= '0;
		end else if (key_strobe) begin
			if (key_pressed) begin
				key_state <= key_state | key_hit;
			end else begin
				key_state <= key_state & ~key_hit;
			end
		end
	end

endmodule

// File: tb_arcade_input.sv
`timescale 1ns/1ps

module tb_arcade_input;

	localparam int wait_limit   = 40;
	localparam int sync_stages  = 2;
	localparam int obs_controls = 0;
	localparam int obs_dip      = 1;
	localparam int obs_reset    = 2;

	logic clock_24;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	arcade_cfg_pkg::apb_addr_t    paddr;
	arcade_cfg_pkg::cfg_word_t    pwdata;
	arcade_cfg_pkg::cfg_word_t    prdata;
	logic pready;
	logic pslverr;
	logic key_strobe;
	logic key_pressed;
	arcade_input_pkg::scan_code_t key_code;
	arcade_input_pkg::joy_t       joystick_0;
	arcade_input_pkg::joy_t       joystick_1;
	logic up_n;
	logic down_n;
	logic left_n;
	logic right_n;
	logic fire_n;
	logic coin_n;
	logic start1_n;
	logic start2_n;
	arcade_cfg_pkg::dip_t         dip_sw;
	logic game_reset_n;

	string test_name;
	int errors;
	int test_errors;
	int tests_failed;
	int waited_cycles;
	int unsigned assert_mark;
	arcade_input_pkg::scan_code_t key_codes [8]; // Indexed by button bit

	arcade_input_top #(.sync_stages(sync_stages)) uut (.*);

	initial begin
		clock_24 = 1'b0;
		forever #5 clock_24 = ~clock_24;
	end

	function automatic logic [7:0] observe(input int sel);
		case (sel)
			obs_controls: return ~{start2_n, start1_n, coin_n, fire_n, up_n, down_n, left_n, right_n};
			obs_dip: return dip_sw;
			default: return {7'b0000000, game_reset_n};
		endcase
	endfunction

	// Rotated monitor: up<-left, down<-right, left<-down, right<-up
	function automatic logic [4:0] turn(input logic [4:0] v);
		return {v[4], v[1], v[0], v[2], v[3]};
	endfunction

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
		assert_mark = uut.u_control_mapper.mapper_chk.fail_count;
	endtask

	task automatic finish_test();
		errors += int'(uut.u_control_mapper.mapper_chk.fail_count - assert_mark);
		if (errors == test_errors) begin
			$display("test %-10s pass", test_name);
		end else begin
			tests_failed++;
			$display("test %-10s fail, %0d errors", test_name, errors - test_errors);
		end
	endtask

	task automatic apb_check(input logic write, input arcade_cfg_pkg::apb_addr_t addr,
		input arcade_cfg_pkg::cfg_word_t data, input logic exp_err);
		int waited;
		@(negedge clock_24);
		psel   = 1'b1;
		pwrite = write;
		paddr  = addr;
		pwdata = write ? data : 8'h00;
		@(negedge clock_24);
		penable = 1'b1;
		waited  = 0;
		#1;
		while (pready !== 1'b1 && waited < wait_limit) begin
			@(negedge clock_24);
			#1;
			waited++;
		end
		if (pready !== 1'b1) begin
			$display("Timeout in %s: pready stayed low at address %h", test_name, addr);
			errors++;
		end
		if (pslverr !== exp_err) begin
			$display("MISMATCH %s: pslverr at %h expected %b, got %b",
				test_name, addr, exp_err, pslverr);
			errors++;
		end
		if (!write && prdata !== data) begin
			$display("MISMATCH %s: read of %h expected %h, got %h",
				test_name, addr, data, prdata);
			errors++;
		end
		@(negedge clock_24);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic key_event(input arcade_input_pkg::scan_code_t code, input logic pressed);
		@(negedge clock_24);
		key_strobe  = 1'b1;
		key_pressed = pressed;
		key_code    = code;
		@(negedge clock_24);
		key_strobe = 1'b0;
	endtask

	task automatic drive_joysticks(output logic [4:0] merged);
		logic [31:0] rnd;
		rnd        = $urandom;
		joystick_0 = rnd[4:0];
		joystick_1 = rnd[12:8];
		merged     = rnd[4:0] | rnd[12:8];
	endtask

	task automatic wait_value(input int sel, input logic [7:0] expected, input string what);
		int waited;
		waited = 0;
		while (observe(sel) !== expected && waited < wait_limit) begin
			@(negedge clock_24);
			waited++;
		end
		waited_cycles = waited;
		if (observe(sel) !== expected) begin
			$display("Timeout in %s: waited %0d cycles for %s", test_name, waited, what);
			errors++;
		end
	endtask

	task automatic check_latency(input int expected, input string what);
		if (waited_cycles != expected) begin
			$display("MISMATCH %s: cycles to %s expected %0d, got %0d",
				test_name, what, expected, waited_cycles);
			errors++;
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic [4:0] pattern;
		logic [4:0] prev;
		int order [8];
		int pick;
		int swap;
		int low_cycles;
		rnd = $urandom(50); // Seeds the generator
		rst         = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		errors       = 0;
		tests_failed = 0;
		key_codes = '{arcade_input_pkg::sc_right, arcade_input_pkg::sc_left,
			arcade_input_pkg::sc_down, arcade_input_pkg::sc_up, arcade_input_pkg::sc_fire,
			arcade_input_pkg::sc_coin, arcade_input_pkg::sc_start1, arcade_input_pkg::sc_start2};

		start_test("reset");
		repeat (3) @(posedge clock_24);
		@(negedge clock_24);
		rst = 1'b0;
		wait_value(obs_reset, 8'h01, "game reset release");
		apb_check(1'b0, arcade_cfg_pkg::cfg_ctrl_addr, 8'h00, 1'b0);
		apb_check(1'b0, arcade_cfg_pkg::cfg_status_addr, 8'h00, 1'b0);
		finish_test();

		start_test("keyboard");
		foreach (order[i]) begin
			order[i] = i;
		end
		for (int i = 7; i > 0; i--) begin
			pick = $urandom_range(i, 0);
			swap = order[i];
			order[i] = order[pick];
			order[pick] = swap;
		end
		foreach (order[i]) begin
			key_event(key_codes[order[i]], 1'b1);
			wait_value(obs_controls, 8'(1 << order[i]), "a pressed key");
			check_latency(1, "a pressed key"); // Strobe edge passes inside key_event
			apb_check(1'b0, arcade_cfg_pkg::cfg_status_addr, 8'(1 << order[i]), 1'b0);
			key_event(key_codes[order[i]], 1'b0);
			wait_value(obs_controls, 8'h00, "the key release");
			check_latency(1, "the key release");
		end
		key_event(8'h1C, 1'b1); // Letter A, not a game key
		apb_check(1'b0, arcade_cfg_pkg::cfg_status_addr, 8'h00, 1'b0);
		key_event(8'h1C, 1'b0);
		finish_test();

		start_test("joystick");
		pattern = '0;
		repeat (8) begin
			prev = pattern;
			drive_joysticks(pattern);
			wait_value(obs_controls, {3'b000, pattern}, "the merged joysticks");
			if (pattern != prev) begin
				check_latency(sync_stages + 2, "the merged joysticks");
			end
			apb_check(1'b0, arcade_cfg_pkg::cfg_status_addr, {3'b000, pattern}, 1'b0);
		end
		finish_test();

		start_test("rotation");
		apb_check(1'b1, arcade_cfg_pkg::cfg_ctrl_addr, 8'h01, 1'b0);
		wait_value(obs_controls, {3'b000, turn(pattern)}, "the rotated controls");
		repeat (6) begin
			prev = pattern;
			drive_joysticks(pattern);
			wait_value(obs_controls, {3'b000, turn(pattern)}, "the rotated joysticks");
			if (pattern != prev) begin
				check_latency(sync_stages + 2, "the rotated joysticks");
			end
			apb_check(1'b0, arcade_cfg_pkg::cfg_status_addr, {3'b000, turn(pattern)}, 1'b0);
		end
		joystick_0 = '0;
		joystick_1 = '0;
		apb_check(1'b1, arcade_cfg_pkg::cfg_ctrl_addr, 8'h00, 1'b0);
		wait_value(obs_controls, 8'h00, "idle controls");
		finish_test();

		start_test("config");
		repeat (4) begin
			rnd = $urandom;
			apb_check(1'b1, arcade_cfg_pkg::cfg_ctrl_addr, {1'b0, rnd[6:2], 2'b00}, 1'b0);
			wait_value(obs_dip, {~rnd[6], 3'b000, rnd[5:2]}, "the DIP byte");
			apb_check(1'b0, arcade_cfg_pkg::cfg_ctrl_addr, {1'b0, rnd[6:2], 2'b00}, 1'b0);
		end
		apb_check(1'b1, arcade_cfg_pkg::cfg_status_addr, 8'h3C, 1'b1);
		apb_check(1'b1, 4'h8, 8'h3C, 1'b1);
		apb_check(1'b0, arcade_cfg_pkg::cfg_ctrl_addr, {1'b0, rnd[6:2], 2'b00}, 1'b0);
		finish_test();

		start_test("game_reset");
		apb_check(1'b1, arcade_cfg_pkg::cfg_ctrl_addr, 8'h02, 1'b0);
		wait_value(obs_reset, 8'h00, "the soft reset");
		low_cycles = 0;
		while (game_reset_n === 1'b0 && low_cycles < wait_limit) begin
			@(negedge clock_24);
			low_cycles++;
		end
		if (low_cycles != 1) begin
			$display("MISMATCH %s: low cycles expected 1, got %0d", test_name, low_cycles);
			errors++;
		end
		apb_check(1'b0, arcade_cfg_pkg::cfg_ctrl_addr, 8'h00, 1'b0);
		key_event(arcade_input_pkg::sc_coin, 1'b1);
		key_event(arcade_input_pkg::sc_start1, 1'b1);
		wait_value(obs_reset, 8'h00, "the coin and start chord");
		repeat (4) @(negedge clock_24); // Chord held
		key_event(arcade_input_pkg::sc_start1, 1'b0);
		wait_value(obs_reset, 8'h01, "release of the chord");
		key_event(arcade_input_pkg::sc_coin, 1'b0);
		finish_test();

		$display("6 tests, %0d failed, %0d errors", tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
